//--- files.f
+incdir+rtl
+incdir+test
rtl/plus_pkg.sv
rtl/cpu_bus_if.sv
rtl/cpu_bus_decode.sv
rtl/video_mode_regs.sv
rtl/asic_reg_bank.sv
rtl/asic_page_ram.sv
rtl/plus_mode_top.sv
test/tb_plus_mode.sv

//--- rtl/asic_page_ram.sv
`timescale 1ns/1ps

`include "plus_params.svh"

module asic_page_ram
    import plus_pkg::*;
(
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      ram_we,
    input  logic      ram_re,
    input  ram_addr_t addr,
    input  byte_t     wdata,
    output byte_t     q
);

    byte_t mem [`PLUS_RAM_DEPTH];

    // Storage array
    always_ff @(posedge clk_sys) begin
        if (ram_we) begin
            mem[addr] <= wdata;
        end
    end

    // Output register where a write shows its own data
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            q <= '0;
        end else if (ram_we) begin
            q <= wdata;
        end else if (ram_re) begin
            q <= mem[addr];
        end
    end

endmodule

//--- rtl/asic_reg_bank.sv
`timescale 1ns/1ps

module asic_reg_bank
    import plus_pkg::*;
(
    input  logic    clk_sys,
    input  logic    reset,
    input  logic    reg_we,
    cpu_bus_if.sink bus,
    output byte_t   reg_rdata
);

    reg_offset_t offset;
    logic        hit;
    logic [3:0]  idx;

    // Sixteen implemented registers packed in offset order
    byte_t regs [16];

    assign offset = bus.addr[7:0];

    // Map a page-7F offset onto a slot in the bank
    always_comb begin
        hit = 1'b1;
        idx = 4'd0;
        case (offset)
            // ASIC control, config, version
            8'h00: idx = 4'd0;
            8'h02: idx = 4'd1;
            8'h03: idx = 4'd2;
            // Video control, status, config, palette, effect
            8'h10: idx = 4'd3;
            8'h11: idx = 4'd4;
            8'h12: idx = 4'd5;
            8'h13: idx = 4'd6;
            8'h14: idx = 4'd7;
            // Sprite control, status, config, priority, collision
            8'h20: idx = 4'd8;
            8'h21: idx = 4'd9;
            8'h22: idx = 4'd10;
            8'h23: idx = 4'd11;
            8'h24: idx = 4'd12;
            // Audio control, config, volume
            8'h30: idx = 4'd13;
            8'h31: idx = 4'd14;
            8'h32: idx = 4'd15;
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && hit) begin
            regs[idx] <= bus.wdata;
        end
    end

    // Holes in the map read as zero
    assign reg_rdata = hit ? regs[idx] : 8'h00;

endmodule

//--- rtl/cpu_bus_decode.sv
`timescale 1ns/1ps

`include "plus_params.svh"

module cpu_bus_decode
    import plus_pkg::*;
(
    cpu_bus_if.sink bus,
    input  logic    plus_mode,
    input  logic    use_asic,
    input  byte_t   ram_q,
    input  byte_t   reg_rdata,
    output logic    mode_we,
    output logic    reg_we,
    output logic    ram_we,
    output logic    ram_re,
    output byte_t   cpu_data_out
);

    byte_t page;
    logic  page_en;
    logic  win_hit;
    logic  mode_hit;
    logic  reg_hit;

    assign page     = bus.addr[15:8];
    assign page_en  = plus_mode && use_asic;
    assign win_hit  = (bus.addr >= `PLUS_RAM_FIRST) && (bus.addr <= `PLUS_RAM_LAST);
    assign mode_hit = (page == `PLUS_MODE_PAGE);
    assign reg_hit  = (page == `PLUS_REG_PAGE);

    // Only even addresses on page BC reach the mode registers
    assign mode_we = bus.wr && mode_hit && !bus.addr[0];
    assign reg_we  = bus.wr && reg_hit;

    // Page 7F writes also reach RAM whether the page is enabled or not
    assign ram_we = bus.wr && ((win_hit && page_en) || reg_hit);
    assign ram_re = bus.rd && win_hit && page_en;

    // Window read first, then register page, then idle bus
    always_comb begin
        if (ram_re) begin
            cpu_data_out = ram_q;
        end else if (reg_hit) begin
            cpu_data_out = reg_rdata;
        end else begin
            cpu_data_out = `PLUS_IDLE_READ;
        end
    end

endmodule

//--- rtl/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if
    import plus_pkg::*;
();

    cpu_addr_t addr;
    byte_t     wdata;
    logic      wr;
    logic      rd;

    // Driven from the top-level CPU pins
    modport source (
        output addr,
        output wdata,
        output wr,
        output rd
    );

    // Decode and register blocks
    modport sink (
        input addr,
        input wdata,
        input wr,
        input rd
    );

endinterface

//--- rtl/plus_mode_top.sv
`timescale 1ns/1ps

module plus_mode_top
    import plus_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       plus_mode,
    input  logic       use_asic,
    input  cpu_addr_t  cpu_addr,
    input  byte_t      cpu_data_in,
    input  logic       cpu_wr,
    input  logic       cpu_rd,
    output byte_t      cpu_data_out,
    output byte_t      config_mode,
    output logic [4:0] mrer_mode,
    output byte_t      asic_mode,
    output logic       asic_enabled
);

    cpu_bus_if bus ();

    logic      mode_we;
    logic      reg_we;
    logic      ram_we;
    logic      ram_re;
    byte_t     ram_q;
    byte_t     reg_rdata;
    ram_addr_t ram_addr;

    // CPU pins onto the internal bus
    assign bus.addr  = cpu_addr;
    assign bus.wdata = cpu_data_in;
    assign bus.wr    = cpu_wr;
    assign bus.rd    = cpu_rd;

    // Low 14 bits also land page 7F at 0x3F00 for the mirror
    assign ram_addr = cpu_addr[13:0];

    cpu_bus_decode u_decode (
        .bus          (bus),
        .plus_mode    (plus_mode),
        .use_asic     (use_asic),
        .ram_q        (ram_q),
        .reg_rdata    (reg_rdata),
        .mode_we      (mode_we),
        .reg_we       (reg_we),
        .ram_we       (ram_we),
        .ram_re       (ram_re),
        .cpu_data_out (cpu_data_out)
    );

    video_mode_regs u_mode_regs (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .plus_mode    (plus_mode),
        .mode_we      (mode_we),
        .bus          (bus),
        .config_mode  (config_mode),
        .mrer_mode    (mrer_mode),
        .asic_mode    (asic_mode),
        .asic_enabled (asic_enabled)
    );

    asic_reg_bank u_reg_bank (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .reg_we    (reg_we),
        .bus       (bus),
        .reg_rdata (reg_rdata)
    );

    asic_page_ram u_ram (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ram_we  (ram_we),
        .ram_re  (ram_re),
        .addr    (ram_addr),
        .wdata   (cpu_data_in),
        .q       (ram_q)
    );

endmodule

//--- rtl/plus_params.svh
`ifndef PLUS_PARAMS_SVH
`define PLUS_PARAMS_SVH

// High address bytes of the two I/O pages
`define PLUS_MODE_PAGE 8'hBC
`define PLUS_REG_PAGE 8'h7F

// CPU window onto the ASIC RAM
`define PLUS_RAM_FIRST 16'h4000
`define PLUS_RAM_LAST 16'h7FFF

// 16 KB of ASIC RAM
`define PLUS_RAM_DEPTH 16384

// Value seen on the data bus when nothing drives it
`define PLUS_IDLE_READ 8'hFF

// Mode bytes that turn the ASIC on in Plus mode
`define PLUS_ASIC_MODE_A 8'h02
`define PLUS_ASIC_MODE_B 8'h62
`define PLUS_ASIC_MODE_C 8'h82

`endif

//--- rtl/plus_pkg.sv
package plus_pkg;

    // CPU data byte
    typedef logic [7:0] byte_t;

    // Full Z80 address
    typedef logic [15:0] cpu_addr_t;

    // Address within the 16 KB ASIC RAM
    typedef logic [13:0] ram_addr_t;

    // Register offset inside page 7F
    typedef logic [7:0] reg_offset_t;

    // Register selector carried in data bits 4:0 of a mode write
    typedef enum logic [4:0] {
        SEL_CONFIG = 5'd0,
        SEL_MRER   = 5'd1,
        SEL_ASIC   = 5'd2
    } mode_sel_t;

endpackage

//--- rtl/video_mode_regs.sv
`timescale 1ns/1ps

`include "plus_params.svh"

module video_mode_regs
    import plus_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       plus_mode,
    input  logic       mode_we,
    cpu_bus_if.sink    bus,
    output byte_t      config_mode,
    output logic [4:0] mrer_mode,
    output byte_t      asic_mode,
    output logic       asic_enabled
);

    logic asic_mode_hit;

    // Modes 02, 62 and 82 select the ASIC video path
    assign asic_mode_hit = (bus.wdata == `PLUS_ASIC_MODE_A) ||
                           (bus.wdata == `PLUS_ASIC_MODE_B) ||
                           (bus.wdata == `PLUS_ASIC_MODE_C);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_mode  <= '0;
            mrer_mode    <= '0;
            asic_mode    <= '0;
            asic_enabled <= 1'b0;
        end else if (mode_we) begin
            // Low five data bits pick the register
            case (bus.wdata[4:0])
                SEL_CONFIG: config_mode <= bus.wdata;
                SEL_MRER:   mrer_mode <= bus.wdata[4:0];
                SEL_ASIC: begin
                    asic_mode    <= bus.wdata;
                    asic_enabled <= asic_mode_hit && plus_mode;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- test/tb_plus_mode_tasks.svh
`ifndef TB_PLUS_MODE_TASKS_SVH
`define TB_PLUS_MODE_TASKS_SVH

task automatic check_byte(input byte_t actual, input byte_t expected, input string msg);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string msg);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch at %0t: %s, got %b, expected %b", $time, msg, actual, expected);
    end
endtask

// One-cycle write strobe
task automatic bus_write(input cpu_addr_t addr, input byte_t data);
    @(negedge clk_sys);
    cpu_addr    = addr;
    cpu_data_in = data;
    cpu_wr      = 1'b1;
    @(negedge clk_sys);
    cpu_wr = 1'b0;
endtask

// rd held for two cycles with data taken in the second
task automatic bus_read(input cpu_addr_t addr, output byte_t data);
    @(negedge clk_sys);
    cpu_addr = addr;
    cpu_rd   = 1'b1;
    @(negedge clk_sys);
    data = cpu_data_out;
    @(negedge clk_sys);
    cpu_rd = 1'b0;
endtask

task automatic read_check(input cpu_addr_t addr, input byte_t expected, input string msg);
    byte_t got;
    bus_read(addr, got);
    check_byte(got, expected, msg);
endtask

// Expected effect of a mode write with its selector in data bits 4:0
task automatic apply_mode_rules(input byte_t data);
    case (data[4:0])
        5'd0: exp_config = data;
        5'd1: exp_mrer = data[4:0];
        5'd2: begin
            exp_asic    = data;
            exp_enabled = plus_mode && (data == 8'h02 || data == 8'h62 || data == 8'h82);
        end
        default: ;
    endcase
endtask

task automatic check_mode_outputs();
    check_byte(config_mode, exp_config, "config_mode");
    check_byte({3'b000, mrer_mode}, {3'b000, exp_mrer}, "mrer_mode");
    check_byte(asic_mode, exp_asic, "asic_mode");
    check_flag(asic_enabled, exp_enabled, "asic_enabled");
endtask

task automatic mode_write(input byte_t data);
    bus_write(16'hBC00, data);
    apply_mode_rules(data);
    check_mode_outputs();
endtask

task automatic test_reset_state();
    exp_config  = 8'h00;
    exp_mrer    = 5'd0;
    exp_asic    = 8'h00;
    exp_enabled = 1'b0;
    check_mode_outputs();
    read_check(16'h7F10, 8'h00, "register 7F10 after reset");
    read_check(16'h1234, 8'hFF, "unmapped read after reset");
endtask

task automatic test_mode_regs();
    plus_mode = 1'b1;
    mode_write(8'h00);
    mode_write(8'h40);
    mode_write(8'h1F);
    mode_write(8'h21);
    mode_write(8'h62);
    mode_write(8'h22);
    // Odd address on page BC is not a mode register
    bus_write(16'hBC01, 8'h00);
    check_mode_outputs();
    plus_mode = 1'b0;
    mode_write(8'h82);
    plus_mode = 1'b1;
endtask

task automatic test_ram_window();
    ram_addr_t offset;
    byte_t     data;
    plus_mode = 1'b1;
    use_asic  = 1'b1;
    for (int i = 0; i < 32; i++) begin
        offset = ram_addr_t'(random_bits(14));
        // Stay below 0x7F00 where the register page starts
        if (offset >= 14'h3F00) begin
            offset = offset - 14'h0100;
        end
        data          = byte_t'(random_bits(8));
        win_addrs[i]  = {2'b01, offset};
        model[offset] = data;
        bus_write(win_addrs[i], data);
    end
    for (int i = 0; i < 32; i++) begin
        read_check(win_addrs[i], model[win_addrs[i][13:0]], "window readback");
    end
endtask

task automatic test_window_disabled();
    cpu_addr_t addr;
    addr     = win_addrs[0];
    use_asic = 1'b0;
    read_check(addr, 8'hFF, "window read with use_asic low");
    bus_write(addr, ~model[addr[13:0]]);
    read_check(win_addrs[1], 8'hFF, "second window read with use_asic low");
    use_asic = 1'b1;
    read_check(addr, model[addr[13:0]], "old value after re-enable");
endtask

task automatic test_reg_bank_mirror();
    reg_offset_t offsets [5];
    byte_t       values [5];
    cpu_addr_t   addr;
    offsets  = '{8'h00, 8'h13, 8'h24, 8'h32, 8'h05};
    use_asic = 1'b0;
    for (int i = 0; i < 5; i++) begin
        values[i] = byte_t'(random_bits(8)) | 8'h01;
        addr      = {8'h7F, offsets[i]};
        bus_write(addr, values[i]);
        model[{6'h3F, offsets[i]}] = values[i];
    end
    for (int i = 0; i < 5; i++) begin
        addr = {8'h7F, offsets[i]};
        // Offset 05 is a hole in the register map
        read_check(addr, (offsets[i] == 8'h05) ? 8'h00 : values[i], "register readback");
    end
    use_asic = 1'b1;
    read_check(16'h7F13, model[14'h3F13], "RAM mirror of 7F13");
    read_check(16'h7F05, model[14'h3F05], "RAM mirror of 7F05");
endtask

`endif

//--- test/tb_plus_mode.sv
`timescale 1ns/1ps

module tb_plus_mode
    import plus_pkg::*;
();

    localparam int NUM_TESTS  = 5;
    localparam int CYCLE_NS   = 8;
    localparam int TIMEOUT_NS = NUM_TESTS * 200 * CYCLE_NS;

    logic       clk_sys;
    logic       reset;
    logic       plus_mode;
    logic       use_asic;
    cpu_addr_t  cpu_addr;
    byte_t      cpu_data_in;
    logic       cpu_wr;
    logic       cpu_rd;
    byte_t      cpu_data_out;
    byte_t      config_mode;
    logic [4:0] mrer_mode;
    byte_t      asic_mode;
    logic       asic_enabled;

    int error_count;
    int check_count;

    // Expected mode register outputs
    byte_t      exp_config;
    logic [4:0] exp_mrer;
    byte_t      exp_asic;
    logic       exp_enabled;

    // Reference copy of the ASIC RAM by low 14 address bits
    byte_t     model [16384];
    cpu_addr_t win_addrs [32];

    logic [16:0] lfsr_state;

    plus_mode_top UUT (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .plus_mode    (plus_mode),
        .use_asic     (use_asic),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_wr       (cpu_wr),
        .cpu_rd       (cpu_rd),
        .cpu_data_out (cpu_data_out),
        .config_mode  (config_mode),
        .mrer_mode    (mrer_mode),
        .asic_mode    (asic_mode),
        .asic_enabled (asic_enabled)
    );

    always #(CYCLE_NS / 2) clk_sys = ~clk_sys;

    // 17-bit Fibonacci LFSR with taps 17 and 14 stepped once per bit
    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            value      = {value[14:0], fb};
        end
        return value;
    endfunction

    `include "tb_plus_mode_tasks.svh"

    initial begin
        clk_sys     = 1'b0;
        reset       = 1'b1;
        plus_mode   = 1'b0;
        use_asic    = 1'b0;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_wr      = 1'b0;
        cpu_rd      = 1'b0;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 17'd71601;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        test_reset_state();
        test_mode_regs();
        test_ram_window();
        test_window_disabled();
        test_reg_bank_mirror();

        repeat (2) @(negedge clk_sys);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule
